// File: design/seq_pkg.sv
// shared constants and types of the command sequencer, referenced by scoped names
package seq_pkg;

    // command word layout
    localparam int CMD_WORD_W        = 32;
    localparam int CMD_ADDR_W        = 10;     // one bank, 1k words
    localparam int PAUSE_W           = 10;     // pause length in bits 9:0
    localparam int CMD_OP_LSB        = 27;     // op field 29:27
    localparam int CMD_OP_W          = 3;
    localparam logic [2:0] CMD_OP_NOP = 3'd0;
    localparam int CMD_DONE_BIT      = 31;     // last word of a sequence
    localparam int CMD_ADD_PAUSE_BIT = 30;     // one idle cycle after this word
    localparam int CMD_BUF_WR_BIT    = 26;     // write buffer strobe request
    localparam int CHN_W             = 4;

    // byte-serial config windows
    localparam logic [9:0] CFG_0BIT_ADDR   = 10'h020;
    localparam logic [9:0] CFG_0BIT_MASK   = 10'h3f0;
    localparam logic [9:0] CFG_16BIT_ADDR  = 10'h050;
    localparam logic [9:0] CFG_16BIT_MASK  = 10'h3f8;

    // zero-bit codes, bit 0 carries the new value
    localparam logic [3:0] CFG_CMDA_EN     = 4'h4;
    localparam logic [3:0] CFG_SDRST_ACT   = 4'h6;
    localparam logic [3:0] CFG_CKE_EN      = 4'h8;

    // 16-bit register offsets
    localparam logic [2:0] CFG_WBUF_DELAY  = 3'h2;   // data bits 3:0 only

    localparam logic [3:0] DFLT_WBUF_DELAY = 4'h6;

    typedef struct packed {
        logic wr;          // write buffer strobe
        logic page_nxt;    // advance buffer to next page
    } wbuf_strobe_t;

    typedef struct packed {
        logic             run;   // first word of a run
        logic [CHN_W-1:0] chn;
    } run_tag_t;

endpackage

// File: design/phy_ctrl_if.sv
// control settings from the config register block to the sequencer and delay lines
interface phy_ctrl_if;

    logic       ddr_rst;      // memory reset active, holds sequencer idle
    logic       cke_en;
    logic       cmda_en;      // command/address outputs enabled
    logic [3:0] wbuf_delay;   // extra write buffer delay in mclk cycles

    modport regs (
        output ddr_rst,
        output cke_en,
        output cmda_en,
        output wbuf_delay
    );

    modport seq (input ddr_rst);

    modport dly (input wbuf_delay);

endinterface

// File: design/cmd_deser.sv
// collects one byte-serial config command and pulses a write when its address hits the window
module cmd_deser #(
    parameter logic [9:0] ADDR      = 10'h000,
    parameter logic [9:0] ADDR_MASK = 10'h3ff,
    parameter int         NUM_BYTES = 2,    // two address bytes plus data bytes
    parameter int         ADDR_W    = 4,
    parameter int         DATA_W    = 0     // zero for commands without data
) (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic [7:0]                           ad_i,
    input  logic                                 stb_i,   // with the first byte
    output logic [ADDR_W-1:0]                    addr_o,
    output logic [((DATA_W > 0) ? DATA_W : 1)-1:0] data_o,
    output logic                                 we_o
);
    localparam int SR_W  = NUM_BYTES * 8;
    localparam int DW    = (DATA_W > 0) ? DATA_W : 1;
    localparam int CNT_W = $clog2(NUM_BYTES + 1);

    logic [SR_W-9:0]  sr;       // earlier bytes, oldest at the bottom
    logic [SR_W+7:0]  cmd_w;    // whole command once the last byte is on ad_i
    logic [CNT_W-1:0] cnt;      // bytes still expected
    logic             last;
    logic             hit;

    assign cmd_w = {8'h00, ad_i, sr};   // zero pad covers the dataless window
    assign last  = (cnt == CNT_W'(1));
    assign hit   = (cmd_w[9:0] & ADDR_MASK) == ADDR;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            we_o <= 1'b0;
        end else begin
            we_o <= last && hit;                // one cycle after the last byte
            if (stb_i)
                cnt <= CNT_W'(NUM_BYTES - 1);
            else if (cnt != '0)
                cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        sr <= cmd_w[SR_W-1:8];                  // shift every cycle, framed by cnt
        if (last) begin
            addr_o <= cmd_w[ADDR_W-1:0];
            data_o <= cmd_w[16 +: DW];
        end
    end

    // a new command must not start inside the previous one
    a_stb_framing: assert property (@(posedge mclk) disable iff (rst)
        stb_i |-> cnt == '0);

endmodule

// File: design/phy_ctrl_regs.sv
// config register block: decodes zero-bit and 16-bit config commands into control settings
module phy_ctrl_regs (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad_i,
    input  logic       cmd_stb_i,
    phy_ctrl_if.regs   ctrl
);
    logic [3:0]  addr0;     // pair index and new value
    logic        we0;
    logic [2:0]  addr16;
    logic [15:0] data16;
    logic        we16;

    cmd_deser #(
        .ADDR      (seq_pkg::CFG_0BIT_ADDR),
        .ADDR_MASK (seq_pkg::CFG_0BIT_MASK),
        .NUM_BYTES (2),
        .ADDR_W    (4),
        .DATA_W    (0)
    ) u_deser_0bit (
        .mclk   (mclk),
        .rst    (rst),
        .ad_i   (cmd_ad_i),
        .stb_i  (cmd_stb_i),
        .addr_o (addr0),
        .data_o (),
        .we_o   (we0)
    );

    cmd_deser #(
        .ADDR      (seq_pkg::CFG_16BIT_ADDR),
        .ADDR_MASK (seq_pkg::CFG_16BIT_MASK),
        .NUM_BYTES (4),
        .ADDR_W    (3),
        .DATA_W    (16)
    ) u_deser_16bit (
        .mclk   (mclk),
        .rst    (rst),
        .ad_i   (cmd_ad_i),
        .stb_i  (cmd_stb_i),
        .addr_o (addr16),
        .data_o (data16),
        .we_o   (we16)
    );

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ctrl.ddr_rst    <= 1'b1;                     // memory held in reset
            ctrl.cke_en     <= 1'b0;
            ctrl.cmda_en    <= 1'b0;
            ctrl.wbuf_delay <= seq_pkg::DFLT_WBUF_DELAY;
        end else begin
            if (we0 && addr0[3:1] == seq_pkg::CFG_CMDA_EN[3:1])
                ctrl.cmda_en <= addr0[0];
            if (we0 && addr0[3:1] == seq_pkg::CFG_SDRST_ACT[3:1])
                ctrl.ddr_rst <= addr0[0];
            if (we0 && addr0[3:1] == seq_pkg::CFG_CKE_EN[3:1])
                ctrl.cke_en <= addr0[0];
            if (we16 && addr16 == seq_pkg::CFG_WBUF_DELAY)
                ctrl.wbuf_delay <= data16[3:0];          // upper bits ignored
        end
    end

endmodule

// File: design/cmd_mem.sv
// one command bank, host write port and registered read port for the sequencer
module cmd_mem #(
    parameter int ADDR_W = 10
) (
    input  logic                           mclk,
    input  logic                           we_i,
    input  logic [ADDR_W-1:0]              waddr_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] wdata_i,
    input  logic                           ren_i,
    input  logic [ADDR_W-1:0]              raddr_i,
    output logic [seq_pkg::CMD_WORD_W-1:0] rdata_o    // held while ren_i is low
);
    logic [seq_pkg::CMD_WORD_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge mclk) begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        if (ren_i)
            rdata_o <= mem[raddr_i];    // one cycle read latency
    end

endmodule

// File: design/cmd_sequencer.sv
// runs a command sequence from one bank up to the done word, with pauses and a four-phase ack
module cmd_sequencer #(
    parameter int CMD_ADDR_W = 10
) (
    input  logic                           mclk,
    input  logic                           rst,
    input  logic                           run_req_i,
    input  logic [CMD_ADDR_W:0]            run_addr_i,    // msb selects the auto bank
    input  logic [seq_pkg::CHN_W-1:0]      run_chn_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] rdata0_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] rdata1_i,
    phy_ctrl_if.seq                        ctrl,
    output logic                           ren0_o,
    output logic                           ren1_o,
    output logic [CMD_ADDR_W-1:0]          raddr_o,
    output logic                           run_ack_o,
    output logic                           run_busy_o,
    output logic                           cmd_valid_o,
    output logic [seq_pkg::CMD_WORD_W-1:0] cmd_word_o,
    output logic                           run_start_o,   // with the first word
    output logic [seq_pkg::CHN_W-1:0]      run_chn_o
);
    logic                        busy;
    logic                        fetch;      // bank word valid this cycle
    logic                        first;      // next word opens the run
    logic                        sel;        // 0 manual, 1 auto
    logic [seq_pkg::PAUSE_W-1:0] pause_cnt;
    logic [seq_pkg::PAUSE_W-1:0] pause_len;
    logic                        start;
    logic                        ren;
    logic                        stall;
    logic                        done;
    logic                        is_nop;

    assign cmd_word_o  = sel ? rdata1_i : rdata0_i;
    assign done        = cmd_word_o[seq_pkg::CMD_DONE_BIT];
    assign is_nop      = cmd_word_o[seq_pkg::CMD_OP_LSB +: seq_pkg::CMD_OP_W] == seq_pkg::CMD_OP_NOP;
    assign pause_len   = cmd_word_o[seq_pkg::PAUSE_W-1:0];

    // hold the read off on a pausing word, then until the counter is down to one
    assign stall = fetch ? (done || cmd_word_o[seq_pkg::CMD_ADD_PAUSE_BIT] ||
                            (is_nop && pause_len != '0))
                         : (pause_cnt > seq_pkg::PAUSE_W'(1));
    assign ren    = busy && !stall;
    assign ren0_o = ren && !sel;
    assign ren1_o = ren && sel;

    assign start       = run_req_i && !run_ack_o && !busy && !ctrl.ddr_rst;
    assign run_busy_o  = busy;
    assign cmd_valid_o = fetch;
    assign run_start_o = fetch && first;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            fetch     <= 1'b0;
            first     <= 1'b0;
            sel       <= 1'b0;
            raddr_o   <= '0;
            run_chn_o <= '0;
            pause_cnt <= '0;
            run_ack_o <= 1'b0;
        end else if (ctrl.ddr_rst) begin            // memory in reset, stay idle
            busy      <= 1'b0;
            fetch     <= 1'b0;
            pause_cnt <= '0;
            run_ack_o <= 1'b0;
        end else begin
            fetch <= ren;
            if (start) begin
                busy      <= 1'b1;
                first     <= 1'b1;
                sel       <= run_addr_i[CMD_ADDR_W];
                raddr_o   <= run_addr_i[CMD_ADDR_W-1:0];
                run_chn_o <= run_chn_i;
            end else begin
                if (fetch && done)
                    busy <= 1'b0;
                if (fetch)
                    first <= 1'b0;
                if (ren)
                    raddr_o <= raddr_o + 1'b1;
            end
            if (fetch && is_nop && !done)
                pause_cnt <= pause_len;             // N idle cycles follow
            else if (pause_cnt != '0)
                pause_cnt <= pause_cnt - 1'b1;
            if (fetch && done)
                run_ack_o <= 1'b1;                  // one cycle after the done word
            else if (!run_req_i)
                run_ack_o <= 1'b0;
        end
    end

    a_ack_needs_req: assert property (@(posedge mclk) disable iff (rst)
        $rose(run_ack_o) |-> $past(run_req_i));

    a_valid_in_run: assert property (@(posedge mclk) disable iff (rst)
        cmd_valid_o |-> run_busy_o);

endmodule

// File: design/wbuf_delay_line.sv
// programmable delay of 1 to 16 cycles for any packed payload, tap chosen by dly_i
module wbuf_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic [3:0] dly_i,    // delay is dly_i + 1 cycles
    input  T           din_i,
    output T           dout_o
);
    T sr [DEPTH];

    assign dout_o = sr[dly_i];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++)
                sr[i] <= '0;                 // no stray strobes after reset
        end else begin
            sr[0] <= din_i;
            for (int i = 1; i < DEPTH; i++)
                sr[i] <= sr[i-1];
        end
    end

endmodule

// File: design/mcontr_seq_top.sv
// top level of the command sequencer: config registers, two banks, sequencer and buffer delays
module mcontr_seq_top #(
    parameter int CMD_ADDR_W = seq_pkg::CMD_ADDR_W
) (
    input  logic                           mclk,
    input  logic                           rst,
    input  logic [7:0]                     cmd_ad_i,
    input  logic                           cmd_stb_i,
    input  logic                           cmd0_we_i,
    input  logic [CMD_ADDR_W-1:0]          cmd0_addr_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] cmd0_data_i,
    input  logic                           cmd1_we_i,
    input  logic [CMD_ADDR_W-1:0]          cmd1_addr_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] cmd1_data_i,
    input  logic                           run_req_i,
    input  logic [CMD_ADDR_W:0]            run_addr_i,
    input  logic [seq_pkg::CHN_W-1:0]      run_chn_i,
    output logic                           run_ack_o,
    output logic                           run_busy_o,
    output logic                           cmd_valid_o,
    output logic [seq_pkg::CMD_WORD_W-1:0] cmd_word_o,
    output logic                           buf_wr_o,
    output logic                           buf_page_nxt_o,
    output logic                           buf_wrun_o,
    output logic [seq_pkg::CHN_W-1:0]      buf_wchn_o,
    output logic                           ddr_rst_o,
    output logic                           cke_o,
    output logic                           cmda_en_o
);
    logic                           ren0;
    logic                           ren1;
    logic [CMD_ADDR_W-1:0]          raddr;
    logic [seq_pkg::CMD_WORD_W-1:0] rdata0;
    logic [seq_pkg::CMD_WORD_W-1:0] rdata1;
    logic                           run_start;
    logic [seq_pkg::CHN_W-1:0]      run_chn;
    logic [3:0]                     tag_dly;     // tag leads the strobes by one
    seq_pkg::wbuf_strobe_t          strb_in;
    seq_pkg::wbuf_strobe_t          strb_out;
    seq_pkg::run_tag_t              tag_in;
    seq_pkg::run_tag_t              tag_out;

    phy_ctrl_if ctrl ();

    assign ddr_rst_o = ctrl.ddr_rst;
    assign cke_o     = ctrl.cke_en;
    assign cmda_en_o = ctrl.cmda_en;
    assign tag_dly   = ctrl.wbuf_delay - 4'd1;

    assign strb_in.wr       = cmd_valid_o && cmd_word_o[seq_pkg::CMD_BUF_WR_BIT];
    assign strb_in.page_nxt = run_start;
    assign tag_in.run       = run_start;
    assign tag_in.chn       = run_chn;

    assign buf_wr_o       = strb_out.wr;
    assign buf_page_nxt_o = strb_out.page_nxt;
    assign buf_wrun_o     = tag_out.run;
    assign buf_wchn_o     = tag_out.chn;

    phy_ctrl_regs u_regs (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_ad_i  (cmd_ad_i),
        .cmd_stb_i (cmd_stb_i),
        .ctrl      (ctrl.regs)
    );

    cmd_mem #(.ADDR_W(CMD_ADDR_W)) u_cmd0 (       // manual bank
        .mclk    (mclk),
        .we_i    (cmd0_we_i),
        .waddr_i (cmd0_addr_i),
        .wdata_i (cmd0_data_i),
        .ren_i   (ren0),
        .raddr_i (raddr),
        .rdata_o (rdata0)
    );

    cmd_mem #(.ADDR_W(CMD_ADDR_W)) u_cmd1 (       // auto bank
        .mclk    (mclk),
        .we_i    (cmd1_we_i),
        .waddr_i (cmd1_addr_i),
        .wdata_i (cmd1_data_i),
        .ren_i   (ren1),
        .raddr_i (raddr),
        .rdata_o (rdata1)
    );

    cmd_sequencer #(.CMD_ADDR_W(CMD_ADDR_W)) u_seq (
        .mclk        (mclk),
        .rst         (rst),
        .run_req_i   (run_req_i),
        .run_addr_i  (run_addr_i),
        .run_chn_i   (run_chn_i),
        .rdata0_i    (rdata0),
        .rdata1_i    (rdata1),
        .ctrl        (ctrl.seq),
        .ren0_o      (ren0),
        .ren1_o      (ren1),
        .raddr_o     (raddr),
        .run_ack_o   (run_ack_o),
        .run_busy_o  (run_busy_o),
        .cmd_valid_o (cmd_valid_o),
        .cmd_word_o  (cmd_word_o),
        .run_start_o (run_start),
        .run_chn_o   (run_chn)
    );

    wbuf_delay_line #(.T(seq_pkg::wbuf_strobe_t)) u_strb_dly (
        .mclk   (mclk),
        .rst    (rst),
        .dly_i  (ctrl.wbuf_delay),
        .din_i  (strb_in),
        .dout_o (strb_out)
    );

    wbuf_delay_line #(.T(seq_pkg::run_tag_t)) u_tag_dly (
        .mclk   (mclk),
        .rst    (rst),
        .dly_i  (tag_dly),
        .din_i  (tag_in),
        .dout_o (tag_out)
    );

endmodule

// File: tests/seq_checker.sv
// testbench checker: samples the DUT on the rising edge and compares words, gaps, ack and strobes
module seq_checker (
    input  logic                           mclk,
    input  logic                           rst,
    input  logic                           run_req_i,
    input  logic                           run_ack_i,
    input  logic                           run_busy_i,
    input  logic                           cmd_valid_i,
    input  logic [seq_pkg::CMD_WORD_W-1:0] cmd_word_i,
    input  logic                           buf_wr_i,
    input  logic                           buf_page_nxt_i,
    input  logic                           buf_wrun_i,
    input  logic [seq_pkg::CHN_W-1:0]      buf_wchn_i,
    input  logic                           ddr_rst_i,
    input  logic                           cke_i,
    input  logic                           cmda_en_i,
    output int                             checks_o,
    output int                             errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [127:0]                   test_name = "reset";
    logic [seq_pkg::CMD_WORD_W-1:0] exp_word [$];
    int                             exp_gap [$];     // -1 marks the first word of a run
    logic [seq_pkg::CHN_W-1:0]      exp_chn [$];
    logic [2:0]                     due [int];       // wrun, page_nxt, wr per sample index
    logic [seq_pkg::CHN_W-1:0]      due_chn [int];
    int                             cyc = 0;
    int                             last_word = 0;
    int                             dly = 6;
    int                             checks = 0;
    int                             errors = 0;
    logic                           prev_req = 1'b0;
    logic                           prev_ack = 1'b0;
    logic                           prev_done = 1'b0;
    logic                           exp_ack;
    logic [2:0]                     exp_pulse;

    assign checks_o = checks;
    assign errors_o = errors;

    task automatic set_test(input logic [127:0] name, input int d);
        test_name = name;
        dly       = d;      // current write buffer delay
    endtask

    task automatic expect_word(input logic [31:0] w, input int gap, input logic [3:0] chn);
        exp_word.push_back(w);
        exp_gap.push_back(gap);
        exp_chn.push_back(chn);
    endtask

    function automatic int pending();
        return exp_word.size() + due.num();
    endfunction

    task automatic compare_value(input logic [127:0] what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %0s: %0s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic add_due(input int k, input logic [2:0] m);
        if (due.exists(k))
            due[k] = due[k] | m;
        else
            due[k] = m;
    endtask

    task automatic check_outputs(input logic e_rst, input logic e_cke, input logic e_cmda);
        compare_value("ddr_rst_o", e_rst, ddr_rst_i);
        compare_value("cke_o", e_cke, cke_i);
        compare_value("cmda_en_o", e_cmda, cmda_en_i);
        compare_value("run_ack_o", 0, run_ack_i);
        compare_value("run_busy_o", 0, run_busy_i);
        compare_value("cmd_valid_o", 0, cmd_valid_i);
        compare_value("buf_wr_o", 0, buf_wr_i);
    endtask

    task automatic take_word();
        logic [31:0] w;
        int          gap;
        if (exp_word.size() == 0) begin
            errors++;
            $display("Error %0s: word %h issued while no word was expected", test_name,
                     cmd_word_i);
        end else begin
            w   = exp_word.pop_front();
            gap = exp_gap.pop_front();
            compare_value("cmd_word_o", w, cmd_word_i);
            if (gap >= 0)
                compare_value("idle cycles", gap, cyc - last_word - 1);
            if (w[seq_pkg::CMD_BUF_WR_BIT])
                add_due(cyc + dly + 1, 3'b001);        // strobe d+1 later
            if (gap < 0) begin
                add_due(cyc + dly + 1, 3'b010);        // page advance with first strobe slot
                add_due(cyc + dly, 3'b100);            // tag one cycle ahead
                due_chn[cyc + dly] = exp_chn[0];
            end
            void'(exp_chn.pop_front());
        end
        last_word = cyc;
    endtask

    always @(posedge mclk) begin
        cyc++;
        if (!rst) begin
            exp_ack = prev_done || (prev_req && prev_ack);   // four-phase ack rule
            compare_value("run_ack_o", exp_ack, run_ack_i);
            if (cmd_valid_i)
                take_word();
            exp_pulse = due.exists(cyc) ? due[cyc] : 3'b000;
            compare_value("buf_wr_o", exp_pulse[0], buf_wr_i);
            compare_value("buf_page_nxt_o", exp_pulse[1], buf_page_nxt_i);
            compare_value("buf_wrun_o", exp_pulse[2], buf_wrun_i);
            if (exp_pulse[2])
                compare_value("buf_wchn_o", due_chn[cyc], buf_wchn_i);
            if (due.exists(cyc))
                due.delete(cyc);
            if (due_chn.exists(cyc))
                due_chn.delete(cyc);
        end
        prev_req  = run_req_i;
        prev_ack  = run_ack_i;
        prev_done = cmd_valid_i && cmd_word_i[seq_pkg::CMD_DONE_BIT];
    end

endmodule

// File: tests/tb_top.sv
// testbench top: clock, reset, stimulus file reader, bank and delay model, DUT and checker
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW      = seq_pkg::CMD_ADDR_W;
    localparam int TIMEOUT = 2000;               // cycles allowed per wait

    logic                           mclk;
    logic                           rst;
    logic [7:0]                     cmd_ad_i;
    logic                           cmd_stb_i;
    logic                           cmd0_we_i;
    logic [AW-1:0]                  cmd0_addr_i;
    logic [seq_pkg::CMD_WORD_W-1:0] cmd0_data_i;
    logic                           cmd1_we_i;
    logic [AW-1:0]                  cmd1_addr_i;
    logic [seq_pkg::CMD_WORD_W-1:0] cmd1_data_i;
    logic                           run_req_i;
    logic [AW:0]                    run_addr_i;
    logic [seq_pkg::CHN_W-1:0]      run_chn_i;
    logic                           run_ack_o;
    logic                           run_busy_o;
    logic                           cmd_valid_o;
    logic [seq_pkg::CMD_WORD_W-1:0] cmd_word_o;
    logic                           buf_wr_o;
    logic                           buf_page_nxt_o;
    logic                           buf_wrun_o;
    logic [seq_pkg::CHN_W-1:0]      buf_wchn_o;
    logic                           ddr_rst_o;
    logic                           cke_o;
    logic                           cmda_en_o;
    int                             checks;
    int                             errors;

    logic [31:0]   bank0 [2**AW];       // model copies of the banks
    logic [31:0]   bank1 [2**AW];
    logic          m_rst = 1'b1;
    logic          m_cke = 1'b0;
    logic          m_cmda = 1'b0;
    logic [3:0]    m_delay = seq_pkg::DFLT_WBUF_DELAY;
    int            tb_errors = 0;       // timeouts and file problems
    int            fd;
    int            r;
    logic [63:0]   kind;
    logic [127:0]  name;
    logic [2047:0] line;                // rest of a comment line, up to 256 characters
    logic [31:0]   f0, f1, f2, f3, f4;

    always #20 mclk = ~mclk;

    mcontr_seq_top #(.CMD_ADDR_W(AW)) uut (.*);

    seq_checker chk (
        .mclk(mclk), .rst(rst), .run_req_i(run_req_i), .run_ack_i(run_ack_o),
        .run_busy_i(run_busy_o), .cmd_valid_i(cmd_valid_o), .cmd_word_i(cmd_word_o),
        .buf_wr_i(buf_wr_o), .buf_page_nxt_i(buf_page_nxt_o), .buf_wrun_i(buf_wrun_o),
        .buf_wchn_i(buf_wchn_o), .ddr_rst_i(ddr_rst_o), .cke_i(cke_o),
        .cmda_en_i(cmda_en_o), .checks_o(checks), .errors_o(errors)
    );

    task automatic write_bank(input logic bank, input logic [31:0] addr, input logic [31:0] data);
        @(negedge mclk);
        cmd0_we_i   = !bank;
        cmd1_we_i   = bank;
        cmd0_addr_i = addr[AW-1:0];
        cmd1_addr_i = addr[AW-1:0];
        cmd0_data_i = data;
        cmd1_data_i = data;
        if (bank)
            bank1[addr[AW-1:0]] = data;
        else
            bank0[addr[AW-1:0]] = data;
        @(negedge mclk);
        cmd0_we_i = 1'b0;
        cmd1_we_i = 1'b0;
    endtask

    task automatic send_config(input int n, input logic [31:0] bytes);
        logic [9:0] addr;
        addr = bytes[9:0];                          // low byte, then bits 1:0 of the high byte
        for (int i = 0; i < n; i++) begin
            @(negedge mclk);
            cmd_stb_i = (i == 0);
            cmd_ad_i  = bytes[8*i +: 8];
        end
        @(negedge mclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = 8'h00;
        repeat (4) @(negedge mclk);                 // 4-byte window still framing
        if (n == 2 && (addr & seq_pkg::CFG_0BIT_MASK) == seq_pkg::CFG_0BIT_ADDR) begin
            if (addr[3:1] == seq_pkg::CFG_CMDA_EN[3:1])
                m_cmda = addr[0];
            if (addr[3:1] == seq_pkg::CFG_SDRST_ACT[3:1])
                m_rst = addr[0];
            if (addr[3:1] == seq_pkg::CFG_CKE_EN[3:1])
                m_cke = addr[0];
        end
        if (n == 4 && (addr & seq_pkg::CFG_16BIT_MASK) == seq_pkg::CFG_16BIT_ADDR &&
            addr[2:0] == seq_pkg::CFG_WBUF_DELAY)
            m_delay = bytes[19:16];                 // only data bits 3:0 count
    endtask

    task automatic wait_ack(input logic level, input logic [127:0] tname);
        int n;
        n = 0;
        while (run_ack_o !== level && n < TIMEOUT) begin
            @(negedge mclk);
            n++;
        end
        if (run_ack_o !== level) begin
            tb_errors++;
            $display("Timeout in %0s: run_ack_o never went to %0b", tname, level);
        end
    endtask

    task automatic wait_drain(input logic [127:0] tname);
        int n;
        n = 0;
        while (chk.pending() != 0 && n < TIMEOUT) begin
            @(negedge mclk);
            n++;
        end
        if (chk.pending() != 0) begin
            tb_errors++;
            $display("Timeout in %0s: expected words or strobes never arrived", tname);
        end
    endtask

    task automatic do_run(input logic [127:0] tname, input logic bank, input logic [31:0] addr,
                          input logic [3:0] chn);
        logic [31:0]   w;
        logic [AW-1:0] a;
        int            gap;
        chk.set_test(tname, m_delay);
        a   = addr[AW-1:0];
        gap = -1;
        if (!m_rst) begin
            for (int i = 0; i < 2**AW; i++) begin     // expected words up to the done word
                w = bank ? bank1[a] : bank0[a];
                chk.expect_word(w, gap, chn);
                if (w[seq_pkg::CMD_DONE_BIT])
                    break;
                if (w[seq_pkg::CMD_OP_LSB +: 3] == 3'd0 && w[seq_pkg::PAUSE_W-1:0] != '0)
                    gap = int'(w[seq_pkg::PAUSE_W-1:0]);
                else if (w[seq_pkg::CMD_ADD_PAUSE_BIT])
                    gap = 1;
                else
                    gap = 0;
                a = a + 1'b1;
            end
        end
        @(negedge mclk);
        run_req_i  = 1'b1;
        run_addr_i = {bank, addr[AW-1:0]};
        run_chn_i  = chn;
        if (m_rst) begin
            repeat (40) begin                       // memory in reset, request must be ignored
                @(negedge mclk);
                chk.check_outputs(m_rst, m_cke, m_cmda);
            end
            run_req_i = 1'b0;
        end else begin
            wait_ack(1'b1, tname);
            run_req_i = 1'b0;
            wait_ack(1'b0, tname);
            wait_drain(tname);
        end
    endtask

    initial begin
        mclk        = 1'b0;
        rst         = 1'b1;
        cmd_ad_i    = 8'h00;
        cmd_stb_i   = 1'b0;
        cmd0_we_i   = 1'b0;
        cmd0_addr_i = '0;
        cmd0_data_i = '0;
        cmd1_we_i   = 1'b0;
        cmd1_addr_i = '0;
        cmd1_data_i = '0;
        run_req_i   = 1'b0;
        run_addr_i  = '0;
        run_chn_i   = '0;
        repeat (8) @(negedge mclk);
        rst = 1'b0;
        fd = $fopen("tests/seq_stimulus.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("Cannot open the stimulus file tests/seq_stimulus.txt");
        end
        while (fd != 0 && $fscanf(fd, "%s", kind) == 1) begin
            case (kind)
                "#": r = $fgets(line, fd);          // column description
                "W": begin
                    r = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    write_bank(f0[0], f1, f2);
                end
                "C": begin
                    r = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    send_config(f0, {f4[7:0], f3[7:0], f2[7:0], f1[7:0]});
                end
                "R": begin
                    r = $fscanf(fd, "%s %h %h %h", name, f0, f1, f2);
                    do_run(name, f0[0], f1, f2[3:0]);
                end
                "E": begin
                    r = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    chk.set_test("ctrl_levels", m_delay);
                    @(negedge mclk);
                    chk.check_outputs(f0[0], f1[0], f2[0]);
                end
                default: begin
                    tb_errors++;
                    $display("Unknown record kind %0s in the stimulus file", kind);
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) @(negedge mclk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, tb_errors);
        if (errors == 0 && tb_errors == 0 && checks > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: tests/seq_stimulus.txt
# W bank addr word | C nbytes b0 b1 b2 b3 | R name bank addr chn | E ddr_rst cke cmda_en
# all fields hex, config bytes in wire order, E also expects ack, busy, valid and buf_wr low
E 1 0 0
W 0 010 08000011
W 0 011 08000022
W 0 012 00000003
W 0 013 10000044
W 0 014 48000055
W 0 015 00000000
W 0 016 88000066
W 1 020 0c000101
W 1 021 0c000102
W 1 022 00000002
W 1 023 14000103
W 1 024 48000104
W 1 025 8c000105
R rst_hold 0 010 3
C 2 26 00 00 00
C 2 29 00 00 00
C 2 25 00 00 00
E 0 1 1
R bank0_run 0 010 3
C 4 52 00 03 00
R bank1_wr 1 020 5
E 0 1 1

// File: project.f
design/seq_pkg.sv
design/phy_ctrl_if.sv
design/cmd_deser.sv
design/phy_ctrl_regs.sv
design/cmd_mem.sv
design/cmd_sequencer.sv
design/wbuf_delay_line.sv
design/mcontr_seq_top.sv
tests/seq_checker.sv
tests/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module tb_top -Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
